// File: rtl/mini_core_pkg.sv
/*
  Shared widths, RV32I encodings and the operation enum of mini_core.
  The values are fixed by the ISA subset and are not meant to be changed.
*/
`default_nettype none

package mini_core_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int unsigned XLEN       = 32;
  localparam int unsigned NR_REGS    = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned INSTR_W    = 32;

  // PC step per fetched word
  localparam int unsigned INSTR_BYTES = 4;

  // AXI4-Lite read response
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // --------------------
  // Major opcodes
  // --------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // funct3 and funct7 values of the supported subset
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

  // --------------------
  // Operations
  // --------------------
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_LUI,
    OP_BEQ,
    OP_BNE,
    OP_ILLEGAL
  } alu_op_e;

endpackage

`default_nettype wire

// File: rtl/mini_core_regfile.sv
/*
  32 x 32-bit register file, two combinational reads and one write.
  x0 reads zero and ignores writes.
*/
`default_nettype none

module mini_core_regfile import mini_core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [REG_ADDR_W-1:0] raddr_a_i,
  input  logic [REG_ADDR_W-1:0] raddr_b_i,
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i,
  output logic [XLEN-1:0]       rdata_a_o,
  output logic [XLEN-1:0]       rdata_b_o
);

  logic [XLEN-1:0] regs_q [NR_REGS];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NR_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// File: rtl/mini_core_fetch.sv
/*
  Instruction fetch over the AXI4-Lite read channels, one read in flight.
  boot_addr_i is sampled once, in the first clock after reset.
  Decode is expected to take the buffer whenever no flush is active.
*/
`default_nettype none

module mini_core_fetch import mini_core_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [XLEN-1:0]    boot_addr_i,
  // AXI4-Lite read, master side
  output logic [XLEN-1:0]    araddr_o,
  output logic               arvalid_o,
  input  logic               arready_i,
  input  logic [XLEN-1:0]    rdata_i,
  input  logic [1:0]         rresp_i,
  input  logic               rvalid_i,
  output logic               rready_o,
  // To decode
  output logic               fetch_valid_o,
  output logic [INSTR_W-1:0] fetch_instr_o,
  output logic [XLEN-1:0]    fetch_pc_o,
  output logic               fetch_err_o,
  input  logic               fetch_ready_i,
  // From execute
  input  logic               redirect_valid_i,
  input  logic [XLEN-1:0]    redirect_pc_i
);

  logic               run_q;
  logic [XLEN-1:0]    pc_q;
  logic               ar_hold_q;
  logic [XLEN-1:0]    ar_addr_q;
  logic               pend_q;
  logic [XLEN-1:0]    pend_pc_q;
  logic               discard_q;
  logic               buf_valid_q;
  logic [INSTR_W-1:0] buf_instr_q;
  logic [XLEN-1:0]    buf_pc_q;
  logic               buf_err_q;

  logic buf_free;
  logic ar_start;
  logic ar_fire;
  logic r_fire;

  // --------------------
  // Read request
  // --------------------
  // Buffer is free if empty or handed to decode this cycle
  assign buf_free  = !buf_valid_q || fetch_ready_i;
  assign ar_start  = run_q && !pend_q && !ar_hold_q && buf_free && !redirect_valid_i;
  // A presented address stays put until arready, even across a redirect
  assign arvalid_o = ar_hold_q || ar_start;
  assign araddr_o  = ar_hold_q ? ar_addr_q : pc_q;
  assign ar_fire   = arvalid_o && arready_i;

  assign rready_o  = pend_q;
  assign r_fire    = rvalid_i && pend_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q       <= 1'b0;
      pc_q        <= '0;
      ar_hold_q   <= 1'b0;
      pend_q      <= 1'b0;
      discard_q   <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      run_q     <= 1'b1;
      ar_hold_q <= arvalid_o && !arready_i;

      if (ar_fire) begin
        pend_q <= 1'b1;
      end else if (r_fire) begin
        pend_q <= 1'b0;
      end

      // Stale request accepted late must not advance the PC
      if (!run_q) begin
        pc_q <= boot_addr_i;
      end else if (redirect_valid_i) begin
        pc_q <= redirect_pc_i;
      end else if (ar_fire && !discard_q) begin
        pc_q <= araddr_o + XLEN'(INSTR_BYTES);
      end

      // Mark the read that is still on the bus as wrong path
      if (redirect_valid_i) begin
        discard_q <= (pend_q && !rvalid_i) || ar_hold_q;
      end else if (r_fire) begin
        discard_q <= 1'b0;
      end

      if (redirect_valid_i) begin
        buf_valid_q <= 1'b0;
      end else if (r_fire && !discard_q) begin
        buf_valid_q <= 1'b1;
      end else if (fetch_ready_i) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    ar_addr_q <= araddr_o;
    if (ar_fire) begin
      pend_pc_q <= araddr_o;
    end
    if (r_fire) begin
      buf_instr_q <= rdata_i;
      buf_pc_q    <= pend_pc_q;
      buf_err_q   <= (rresp_i != RESP_OKAY);
    end
  end

  assign fetch_valid_o = buf_valid_q;
  assign fetch_instr_o = buf_instr_q;
  assign fetch_pc_o    = buf_pc_q;
  assign fetch_err_o   = buf_err_q;

endmodule

`default_nettype wire

// File: rtl/mini_core_decode.sv
/*
  Decode stage register. Unsupported encodings and fetch errors become
  OP_ILLEGAL. rd reads as zero for branches and illegal words.
*/
`default_nettype none

module mini_core_decode import mini_core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  fetch_valid_i,
  input  logic [INSTR_W-1:0]    fetch_instr_i,
  input  logic [XLEN-1:0]       fetch_pc_i,
  input  logic                  fetch_err_i,
  input  logic                  flush_i,
  output logic                  fetch_ready_o,
  output logic                  dec_valid_o,
  output alu_op_e               dec_op_o,
  output logic [REG_ADDR_W-1:0] dec_rd_o,
  output logic [REG_ADDR_W-1:0] dec_rs1_o,
  output logic [REG_ADDR_W-1:0] dec_rs2_o,
  output logic [XLEN-1:0]       dec_imm_o,
  output logic [XLEN-1:0]       dec_pc_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  alu_op_e         op_d;
  logic [XLEN-1:0] imm_d;
  logic            take;

  logic                  valid_q;
  alu_op_e               op_q;
  logic [REG_ADDR_W-1:0] rd_q;
  logic [REG_ADDR_W-1:0] rs1_q;
  logic [REG_ADDR_W-1:0] rs2_q;
  logic [XLEN-1:0]       imm_q;
  logic [XLEN-1:0]       pc_q;

  // Execute never stalls, so only a flush holds fetch off
  assign fetch_ready_o = !flush_i;
  assign take          = fetch_valid_i && fetch_ready_o;

  assign opcode = fetch_instr_i[6:0];
  assign funct3 = fetch_instr_i[14:12];
  assign funct7 = fetch_instr_i[31:25];

  // --------------------
  // Operation decode
  // --------------------
  always_comb begin
    op_d  = OP_ILLEGAL;
    imm_d = '0;
    case (opcode)
      OPC_OP: begin
        if (funct7 == F7_BASE) begin
          case (funct3)
            F3_ADD_SUB: op_d = OP_ADD;
            F3_XOR:     op_d = OP_XOR;
            F3_OR:      op_d = OP_OR;
            F3_AND:     op_d = OP_AND;
            default:    op_d = OP_ILLEGAL;
          endcase
        end else if (funct7 == F7_SUB && funct3 == F3_ADD_SUB) begin
          op_d = OP_SUB;
        end
      end
      OPC_OP_IMM: begin
        if (funct3 == F3_ADD_SUB) begin
          op_d = OP_ADDI;
        end
        imm_d = {{20{fetch_instr_i[31]}}, fetch_instr_i[31:20]};
      end
      OPC_LUI: begin
        op_d  = OP_LUI;
        imm_d = {fetch_instr_i[31:12], 12'b0};
      end
      OPC_BRANCH: begin
        if (funct3 == F3_BEQ) begin
          op_d = OP_BEQ;
        end else if (funct3 == F3_BNE) begin
          op_d = OP_BNE;
        end
        // B-type offset, bit 0 always zero
        imm_d = {{20{fetch_instr_i[31]}}, fetch_instr_i[7], fetch_instr_i[30:25],
                 fetch_instr_i[11:8], 1'b0};
      end
      default: op_d = OP_ILLEGAL;
    endcase
    // Bad bus response overrides whatever the word looks like
    if (fetch_err_i) begin
      op_d = OP_ILLEGAL;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= take;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      op_q  <= op_d;
      rd_q  <= (op_d == OP_BEQ || op_d == OP_BNE || op_d == OP_ILLEGAL) ?
               '0 : fetch_instr_i[11:7];
      rs1_q <= fetch_instr_i[19:15];
      rs2_q <= fetch_instr_i[24:20];
      imm_q <= imm_d;
      pc_q  <= fetch_pc_i;
    end
  end

  assign dec_valid_o = valid_q;
  assign dec_op_o    = op_q;
  assign dec_rd_o    = rd_q;
  assign dec_rs1_o   = rs1_q;
  assign dec_rs2_o   = rs2_q;
  assign dec_imm_o   = imm_q;
  assign dec_pc_o    = pc_q;

endmodule

`default_nettype wire

// File: rtl/mini_core_execute.sv
/*
  Combinational execute and commit. Every valid decode entry retires in
  the cycle it is presented. A taken branch raises a one-cycle redirect.
*/
`default_nettype none

module mini_core_execute import mini_core_pkg::*; (
  input  logic                  dec_valid_i,
  input  alu_op_e               dec_op_i,
  input  logic [REG_ADDR_W-1:0] dec_rd_i,
  input  logic [REG_ADDR_W-1:0] dec_rs1_i,
  input  logic [REG_ADDR_W-1:0] dec_rs2_i,
  input  logic [XLEN-1:0]       dec_imm_i,
  input  logic [XLEN-1:0]       dec_pc_i,
  // Register file
  output logic [REG_ADDR_W-1:0] rs1_addr_o,
  output logic [REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [XLEN-1:0]       rs1_data_i,
  input  logic [XLEN-1:0]       rs2_data_i,
  output logic                  rf_we_o,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic [XLEN-1:0]       rf_wdata_o,
  // Flush of younger state
  output logic                  redirect_valid_o,
  output logic [XLEN-1:0]       redirect_pc_o,
  // Commit port
  output logic                  commit_valid_o,
  output logic [XLEN-1:0]       commit_pc_o,
  output logic [REG_ADDR_W-1:0] commit_rd_o,
  output logic                  commit_we_o,
  output logic [XLEN-1:0]       commit_wdata_o,
  output logic                  commit_illegal_o
);

  logic [XLEN-1:0] result;
  logic            writes_rd;
  logic            taken;

  assign rs1_addr_o = dec_rs1_i;
  assign rs2_addr_o = dec_rs2_i;

  // --------------------
  // ALU and compare
  // --------------------
  always_comb begin
    result    = '0;
    writes_rd = 1'b1;
    taken     = 1'b0;
    case (dec_op_i)
      OP_ADD:  result = rs1_data_i + rs2_data_i;
      OP_SUB:  result = rs1_data_i - rs2_data_i;
      OP_AND:  result = rs1_data_i & rs2_data_i;
      OP_OR:   result = rs1_data_i | rs2_data_i;
      OP_XOR:  result = rs1_data_i ^ rs2_data_i;
      OP_ADDI: result = rs1_data_i + dec_imm_i;
      OP_LUI:  result = dec_imm_i;
      OP_BEQ: begin
        writes_rd = 1'b0;
        taken     = (rs1_data_i == rs2_data_i);
      end
      OP_BNE: begin
        writes_rd = 1'b0;
        taken     = (rs1_data_i != rs2_data_i);
      end
      default: writes_rd = 1'b0;
    endcase
  end

  // Write-back, x0 never written
  assign rf_we_o    = dec_valid_i && writes_rd && (dec_rd_i != '0);
  assign rf_waddr_o = dec_rd_i;
  assign rf_wdata_o = result;

  assign redirect_valid_o = dec_valid_i && taken;
  assign redirect_pc_o    = dec_pc_i + dec_imm_i;

  // --------------------
  // Commit port
  // --------------------
  assign commit_valid_o   = dec_valid_i;
  assign commit_pc_o      = dec_pc_i;
  assign commit_rd_o      = dec_rd_i;
  assign commit_we_o      = rf_we_o;
  assign commit_wdata_o   = result;
  assign commit_illegal_o = dec_valid_i && (dec_op_i == OP_ILLEGAL);

endmodule

`default_nettype wire

// File: rtl/mini_core.sv
/*
  mini_core top level. Instruction fetch only, over AXI4-Lite read.
  The commit port reports one retired instruction per cycle at most.
*/
`default_nettype none

module mini_core import mini_core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [XLEN-1:0]       boot_addr_i,
  // AXI4-Lite read, master side
  output logic [XLEN-1:0]       araddr_o,
  output logic                  arvalid_o,
  input  logic                  arready_i,
  input  logic [XLEN-1:0]       rdata_i,
  input  logic [1:0]            rresp_i,
  input  logic                  rvalid_i,
  output logic                  rready_o,
  // Commit port
  output logic                  commit_valid_o,
  output logic [XLEN-1:0]       commit_pc_o,
  output logic [REG_ADDR_W-1:0] commit_rd_o,
  output logic                  commit_we_o,
  output logic [XLEN-1:0]       commit_wdata_o,
  output logic                  commit_illegal_o
);

  // Fetch to decode
  logic               fetch_valid;
  logic               fetch_ready;
  logic [INSTR_W-1:0] fetch_instr;
  logic [XLEN-1:0]    fetch_pc;
  logic               fetch_err;

  // Decode to execute
  logic                  dec_valid;
  alu_op_e               dec_op;
  logic [REG_ADDR_W-1:0] dec_rd;
  logic [REG_ADDR_W-1:0] dec_rs1;
  logic [REG_ADDR_W-1:0] dec_rs2;
  logic [XLEN-1:0]       dec_imm;
  logic [XLEN-1:0]       dec_pc;

  // Execute and register file
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;

  // Taken branch flush
  logic            redirect_valid;
  logic [XLEN-1:0] redirect_pc;

  mini_core_fetch i_fetch (
    .clk_i            ( clk_i          ),
    .rst_ni           ( rst_ni         ),
    .boot_addr_i      ( boot_addr_i    ),
    .araddr_o         ( araddr_o       ),
    .arvalid_o        ( arvalid_o      ),
    .arready_i        ( arready_i      ),
    .rdata_i          ( rdata_i        ),
    .rresp_i          ( rresp_i        ),
    .rvalid_i         ( rvalid_i       ),
    .rready_o         ( rready_o       ),
    .fetch_valid_o    ( fetch_valid    ),
    .fetch_instr_o    ( fetch_instr    ),
    .fetch_pc_o       ( fetch_pc       ),
    .fetch_err_o      ( fetch_err      ),
    .fetch_ready_i    ( fetch_ready    ),
    .redirect_valid_i ( redirect_valid ),
    .redirect_pc_i    ( redirect_pc    )
  );

  mini_core_decode i_decode (
    .clk_i         ( clk_i          ),
    .rst_ni        ( rst_ni         ),
    .fetch_valid_i ( fetch_valid    ),
    .fetch_instr_i ( fetch_instr    ),
    .fetch_pc_i    ( fetch_pc       ),
    .fetch_err_i   ( fetch_err      ),
    .flush_i       ( redirect_valid ),
    .fetch_ready_o ( fetch_ready    ),
    .dec_valid_o   ( dec_valid      ),
    .dec_op_o      ( dec_op         ),
    .dec_rd_o      ( dec_rd         ),
    .dec_rs1_o     ( dec_rs1        ),
    .dec_rs2_o     ( dec_rs2        ),
    .dec_imm_o     ( dec_imm        ),
    .dec_pc_o      ( dec_pc         )
  );

  mini_core_regfile i_regfile (
    .clk_i     ( clk_i    ),
    .rst_ni    ( rst_ni   ),
    .raddr_a_i ( rs1_addr ),
    .raddr_b_i ( rs2_addr ),
    .we_i      ( rf_we    ),
    .waddr_i   ( rf_waddr ),
    .wdata_i   ( rf_wdata ),
    .rdata_a_o ( rs1_data ),
    .rdata_b_o ( rs2_data )
  );

  mini_core_execute i_execute (
    .dec_valid_i      ( dec_valid        ),
    .dec_op_i         ( dec_op           ),
    .dec_rd_i         ( dec_rd           ),
    .dec_rs1_i        ( dec_rs1          ),
    .dec_rs2_i        ( dec_rs2          ),
    .dec_imm_i        ( dec_imm          ),
    .dec_pc_i         ( dec_pc           ),
    .rs1_addr_o       ( rs1_addr         ),
    .rs2_addr_o       ( rs2_addr         ),
    .rs1_data_i       ( rs1_data         ),
    .rs2_data_i       ( rs2_data         ),
    .rf_we_o          ( rf_we            ),
    .rf_waddr_o       ( rf_waddr         ),
    .rf_wdata_o       ( rf_wdata         ),
    .redirect_valid_o ( redirect_valid   ),
    .redirect_pc_o    ( redirect_pc      ),
    .commit_valid_o   ( commit_valid_o   ),
    .commit_pc_o      ( commit_pc_o      ),
    .commit_rd_o      ( commit_rd_o      ),
    .commit_we_o      ( commit_we_o      ),
    .commit_wdata_o   ( commit_wdata_o   ),
    .commit_illegal_o ( commit_illegal_o )
  );

endmodule

`default_nettype wire

// File: verif/tb_mini_core.sv
/*
  Testbench for mini_core. An AXI4-Lite read memory with random delays
  serves a fixed program, and a reference model checks every commit.
  The run ends when the closing self-loop branch commits.
*/
`default_nettype none

module tb_mini_core import mini_core_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int          PROG_LEN    = 23;
  localparam int          MAX_CYCLES  = 40 * PROG_LEN + 10;
  localparam logic [31:0] BOOT_ADDR   = 32'h0000_0400;
  localparam logic [31:0] SLVERR_ADDR = BOOT_ADDR + 32'd60;
  localparam logic [31:0] END_ADDR    = BOOT_ADDR + 32'd88;

  logic                  clk_i;
  logic                  rst_ni;
  logic [XLEN-1:0]       boot_addr_i;
  logic [XLEN-1:0]       araddr_o;
  logic                  arvalid_o;
  logic                  arready_i;
  logic [XLEN-1:0]       rdata_i;
  logic [1:0]            rresp_i;
  logic                  rvalid_i;
  logic                  rready_o;
  logic                  commit_valid_o;
  logic [XLEN-1:0]       commit_pc_o;
  logic [REG_ADDR_W-1:0] commit_rd_o;
  logic                  commit_we_o;
  logic [XLEN-1:0]       commit_wdata_o;
  logic                  commit_illegal_o;

  logic [31:0] prog [PROG_LEN];
  logic [31:0] ref_regs [32];
  logic [31:0] ref_pc;
  int          last_r_cycle [PROG_LEN];
  logic [31:0] lcg_state;

  // Memory model state
  logic        pending;
  logic [31:0] pend_addr;
  logic [1:0]  ar_cnt;
  logic [1:0]  r_cnt;
  logic        ar_stalled;
  logic [31:0] held_addr;
  logic        first_ar_seen;

  int   cycle_cnt;
  int   commit_count;
  int   check_errors;
  int   timeout_errors;
  logic done;
  logic timed_out;

  mini_core i_mini_core (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .boot_addr_i      ( boot_addr_i      ),
    .araddr_o         ( araddr_o         ),
    .arvalid_o        ( arvalid_o        ),
    .arready_i        ( arready_i        ),
    .rdata_i          ( rdata_i          ),
    .rresp_i          ( rresp_i          ),
    .rvalid_i         ( rvalid_i         ),
    .rready_o         ( rready_o         ),
    .commit_valid_o   ( commit_valid_o   ),
    .commit_pc_o      ( commit_pc_o      ),
    .commit_rd_o      ( commit_rd_o      ),
    .commit_we_o      ( commit_we_o      ),
    .commit_wdata_o   ( commit_wdata_o   ),
    .commit_illegal_o ( commit_illegal_o )
  );

  always #20 clk_i = ~clk_i;

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [1:0] next_delay();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[17:16];
  endfunction

  function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] addi_word(logic [11:0] imm, logic [4:0] rs1, logic [4:0] rd);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] lui_word(logic [19:0] imm, logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] branch_word(logic [12:0] off, logic [4:0] rs2,
                                              logic [4:0] rs1, logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  // -1 outside the program area
  function automatic int prog_index(logic [31:0] addr);
    if (addr[1:0] == 2'b00 && addr >= BOOT_ADDR && addr < BOOT_ADDR + 32'(4 * PROG_LEN)) begin
      return int'((addr - BOOT_ADDR) >> 2);
    end
    return -1;
  endfunction

  // Outside the program the fill depends on every address bit
  function automatic logic [31:0] mem_contents(logic [31:0] addr);
    int idx;
    idx = prog_index(addr);
    if (idx >= 0) begin
      return prog[idx];
    end
    return {addr[31:16] ^ addr[15:0], ~addr[15:0]};
  endfunction

  task automatic log_mismatch(string sig, logic [31:0] exp_val, logic [31:0] act_val);
    check_errors++;
    $display("Error at %0t ns: %s expected %h, actual %h", $time, sig, exp_val, act_val);
  endtask

  task automatic flag_violation(string msg);
    check_errors++;
    $display("Check failed at %0t ns: %s", $time, msg);
  endtask

  // Covers every operation, both branch outcomes, an unknown opcode and a SLVERR
  task automatic load_program();
    prog[0]  = lui_word(20'h12345, 5'd1);
    prog[1]  = addi_word(12'h7FF, 5'd0, 5'd2);
    prog[2]  = addi_word(12'hFFD, 5'd0, 5'd3);
    prog[3]  = r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd4);
    prog[4]  = r_type(7'h20, 5'd3, 5'd2, 3'd0, 5'd5);
    prog[5]  = r_type(7'h00, 5'd3, 5'd4, 3'd7, 5'd6);
    prog[6]  = r_type(7'h00, 5'd3, 5'd1, 3'd6, 5'd7);
    prog[7]  = r_type(7'h00, 5'd5, 5'd4, 3'd4, 5'd8);
    prog[8]  = addi_word(12'h005, 5'd0, 5'd0);
    prog[9]  = r_type(7'h00, 5'd2, 5'd0, 3'd0, 5'd9);
    prog[10] = branch_word(13'd8, 5'd2, 5'd1, 3'd0);
    prog[11] = branch_word(13'd12, 5'd2, 5'd1, 3'd1);
    prog[12] = addi_word(12'h001, 5'd0, 5'd10);
    prog[13] = addi_word(12'h002, 5'd0, 5'd11);
    prog[14] = 32'h0000_050B;
    prog[15] = addi_word(12'h055, 5'd0, 5'd12);
    prog[16] = addi_word(12'h001, 5'd12, 5'd13);
    prog[17] = branch_word(13'd12, 5'd0, 5'd0, 3'd0);
    prog[18] = addi_word(12'h003, 5'd0, 5'd14);
    prog[19] = addi_word(12'h004, 5'd0, 5'd15);
    prog[20] = branch_word(13'd8, 5'd2, 5'd9, 3'd1);
    prog[21] = addi_word(12'h100, 5'd13, 5'd16);
    prog[22] = branch_word(13'd0, 5'd0, 5'd0, 3'd0);
  endtask

  // --------------------
  // Reference model
  // --------------------
  task automatic check_commit();
    logic [31:0] word;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] exp_wdata;
    logic        exp_alu;
    logic        exp_illegal;
    logic        exp_we;
    logic        taken;
    int          idx;
    word  = mem_contents(ref_pc);
    f7    = word[31:25];
    f3    = word[14:12];
    rd    = word[11:7];
    a     = ref_regs[word[19:15]];
    b     = ref_regs[word[24:20]];
    imm_i = {{20{word[31]}}, word[31:20]};
    imm_b = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    exp_wdata   = '0;
    exp_alu     = 1'b1;
    exp_illegal = (ref_pc == SLVERR_ADDR);
    taken       = 1'b0;
    case (word[6:0])
      7'b0110011: begin
        case ({f7, f3})
          {7'h00, 3'd0}: exp_wdata = a + b;
          {7'h20, 3'd0}: exp_wdata = a - b;
          {7'h00, 3'd4}: exp_wdata = a ^ b;
          {7'h00, 3'd6}: exp_wdata = a | b;
          {7'h00, 3'd7}: exp_wdata = a & b;
          default:       exp_illegal = 1'b1;
        endcase
      end
      7'b0010011: begin
        exp_wdata = a + imm_i;
        exp_illegal = exp_illegal || (f3 != 3'd0);
      end
      7'b0110111: exp_wdata = {word[31:12], 12'b0};
      7'b1100011: begin
        exp_alu = 1'b0;
        case (f3)
          3'd0:    taken = (a == b);
          3'd1:    taken = (a != b);
          default: exp_illegal = 1'b1;
        endcase
      end
      default: exp_illegal = 1'b1;
    endcase
    // A bad fetch or unknown word retires without effect
    if (exp_illegal) begin
      exp_alu = 1'b0;
      taken   = 1'b0;
    end
    exp_we = exp_alu && (rd != 5'd0);

    assert (commit_pc_o == ref_pc) else log_mismatch("commit_pc_o", ref_pc, commit_pc_o);
    assert (commit_illegal_o == exp_illegal)
      else log_mismatch("commit_illegal_o", 32'(exp_illegal), 32'(commit_illegal_o));
    assert (commit_we_o == exp_we)
      else log_mismatch("commit_we_o", 32'(exp_we), 32'(commit_we_o));
    if (exp_alu) begin
      assert (commit_rd_o == rd) else log_mismatch("commit_rd_o", 32'(rd), 32'(commit_rd_o));
      assert (commit_wdata_o == exp_wdata)
        else log_mismatch("commit_wdata_o", exp_wdata, commit_wdata_o);
    end
    idx = prog_index(commit_pc_o);
    if (idx >= 0) begin
      assert (cycle_cnt - last_r_cycle[idx] == 2)
        else log_mismatch("commit latency", 32'd2, 32'(cycle_cnt - last_r_cycle[idx]));
    end

    if (exp_we) begin
      ref_regs[rd] = exp_wdata;
    end
    if (ref_pc == END_ADDR) begin
      done = 1'b1;
    end
    ref_pc = taken ? ref_pc + imm_b : ref_pc + 32'd4;
    commit_count++;
  endtask

  // --------------------
  // Bus model and checks
  // --------------------
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      timed_out = 1'b1;
    end
    if (!rst_ni) begin
      assert (!arvalid_o && !rready_o && !commit_valid_o)
        else flag_violation("arvalid_o, rready_o or commit_valid_o high during reset");
    end else begin
      assert (!pending || rready_o) else flag_violation("rready_o low with a read outstanding");
      if (rvalid_i && rready_o) begin
        pending = 1'b0;
        if (prog_index(pend_addr) >= 0) begin
          last_r_cycle[prog_index(pend_addr)] = cycle_cnt;
        end
      end else if (pending && r_cnt != 2'd0) begin
        r_cnt--;
      end

      if (arvalid_o) begin
        assert (araddr_o[1:0] == 2'b00) else flag_violation("araddr_o is not word-aligned");
      end
      if (ar_stalled) begin
        assert (arvalid_o && araddr_o == held_addr)
          else flag_violation("AR request dropped or changed before arready_i");
      end
      if (arvalid_o && !first_ar_seen) begin
        assert (araddr_o == BOOT_ADDR) else log_mismatch("araddr_o", BOOT_ADDR, araddr_o);
        first_ar_seen = 1'b1;
      end
      if (arvalid_o && arready_i) begin
        assert (!pending) else flag_violation("second AR issued before the previous R beat");
        pending   = 1'b1;
        pend_addr = araddr_o;
        r_cnt     = next_delay();
        ar_cnt    = next_delay();
      end else if (arvalid_o && ar_cnt != 2'd0) begin
        ar_cnt--;
      end
      ar_stalled = arvalid_o && !arready_i;
      held_addr  = araddr_o;

      if (commit_valid_o) begin
        check_commit();
      end
    end

    #2;
    arready_i = (ar_cnt == 2'd0);
    rvalid_i  = pending && (r_cnt == 2'd0);
    rdata_i   = rvalid_i ? mem_contents(pend_addr) : '0;
    rresp_i   = (rvalid_i && pend_addr == SLVERR_ADDR) ? 2'b10 : RESP_OKAY;
  end

  initial begin
    clk_i          = 1'b0;
    rst_ni         = 1'b1;
    boot_addr_i    = BOOT_ADDR;
    arready_i      = 1'b0;
    rdata_i        = '0;
    rresp_i        = RESP_OKAY;
    rvalid_i       = 1'b0;
    lcg_state      = 32'd26967;
    pending        = 1'b0;
    pend_addr      = '0;
    ar_cnt         = 2'd0;
    r_cnt          = 2'd0;
    ar_stalled     = 1'b0;
    held_addr      = '0;
    first_ar_seen  = 1'b0;
    cycle_cnt      = 0;
    commit_count   = 0;
    check_errors   = 0;
    timeout_errors = 0;
    done           = 1'b0;
    timed_out      = 1'b0;
    ref_pc         = BOOT_ADDR;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      last_r_cycle[i] = -100;
    end
    load_program();

    // Give the async reset a real falling edge
    #1;
    rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    wait (done || timed_out);
    if (!done) begin
      timeout_errors++;
      $display("Timeout after %0d cycles, the final branch never committed", cycle_cnt);
    end
    $display("Errors: %0d check, %0d timeout (%0d instructions committed)",
             check_errors, timeout_errors, commit_count);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mini_core.f
rtl/mini_core_pkg.sv
rtl/mini_core_regfile.sv
rtl/mini_core_fetch.sv
rtl/mini_core_decode.sv
rtl/mini_core_execute.sv
rtl/mini_core.sv
verif/tb_mini_core.sv

// File: run_sim.sh
#!/bin/sh
# Builds the mini_core testbench with Verilator and runs it.
# Exits nonzero on a build error, a crashed run or a failing test.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_mini_core \
  -f mini_core.f \
  -Mdir "$BUILD_DIR" -o Vtb_mini_core
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_mini_core" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi
exit 0
